/* project.f */
source/cpuPkg.sv
source/aluUnit.sv
source/controlUnit.sv
source/hazardUnit.sv
source/pipeReg.sv
source/regFile.sv
source/mipsCore.sv
tests/mipsCoreTb.sv

/* run.sh */
#!/bin/sh
# Build the MIPS core testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module mipsCoreTb -f project.f -o mipsCoreSim \
    && ./obj_dir/mipsCoreSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Simulation did not build or run"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && { echo "Result: FAIL"; exit 1; } || { echo "Result: PASS"; exit 0; }

/* tests/mipsCoreTb.sv */
/*
 * Testbench for the five-stage MIPS core.
 * Models the instruction and data memories and assembles small programs.
 * Each directed test compares the stores it sees with values worked out
 * from the instruction rules.
 */
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;
    import cpuPkg::*;

    localparam int resetCycles = 10;
    localparam int testCycles  = 60;
    localparam int numTests    = 4;
    localparam int memWords    = 256;
    localparam int cycleLimit  = numTests * (resetCycles + testCycles + 2) + 100;

    logic                 clk;
    logic                 arstN;
    logic [addrWidth-1:0] instAddr;
    logic [dataWidth-1:0] instData;
    logic [addrWidth-1:0] dataAddr;
    logic                 dataWrite;
    logic                 dataRead;
    logic [dataWidth-1:0] dataOut;
    logic [dataWidth-1:0] dataIn;

    logic [31:0] imem [0:memWords-1];
    logic [31:0] dmem [0:memWords-1];
    logic [31:0] storeAddrLog [$];
    logic [31:0] storeDataLog [$];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] rngState = 32'h86c6bbc3;
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    int          progLen = 0;
    int          firstStoreCycle = 0;
    string       testName = "";

    // Unwritten data words hold a value tied to their full address
    function automatic logic [31:0] fillWord(input logic [addrWidth-1:0] addr);
        return {addr, 2'b01} ^ 32'hc3a5_0f96;
    endfunction

    // Both memories answer in the same cycle; fetch past the array reads no-ops
    assign instData = (instAddr[addrWidth-1:8] == '0) ? imem[instAddr[7:0]] : '0;
    // Load data only while dataRead is high
    assign dataIn   = !dataRead ? '0
                    : (dataAddr[addrWidth-1:8] == '0) ? dmem[dataAddr[7:0]]
                                                      : fillWord(dataAddr);

    mipsCore UUT (
        .clk       (clk),
        .arstN     (arstN),
        .instAddr  (instAddr),
        .instData  (instData),
        .dataAddr  (dataAddr),
        .dataWrite (dataWrite),
        .dataRead  (dataRead),
        .dataOut   (dataOut),
        .dataIn    (dataIn)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [31:0] signExtend(input logic [15:0] value);
        return {{16{value[15]}}, value};
    endfunction

    // Instruction encoders in MIPS field order
    function automatic logic [31:0] rFormat(input logic [5:0] fn, input logic [4:0] rd,
                                            input logic [4:0] rs, input logic [4:0] rt);
        return {opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iFormat(input logic [5:0] op, input logic [4:0] rt,
                                            input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jFormat(input logic [25:0] targetWord);
        return {opJ, targetWord};
    endfunction

    task automatic appendInstr(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic expectStore(input logic [31:0] wordAddr, input logic [31:0] value);
        expAddr.push_back(wordAddr);
        expData.push_back(value);
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("Mismatch %s in %s: got %h, expected %h",
                     name, testName, actual, expected);
        end
    endtask

    task automatic quietOutputs();
        compareValue("dataWrite", {31'd0, dataWrite}, 32'h0);
        compareValue("dataRead", {31'd0, dataRead}, 32'h0);
        compareValue("instAddr", {2'b00, instAddr}, 32'h0);
    endtask

    // Puts the core in reset and clears memories and logs
    task automatic startTest(input string name);
        testName = name;
        @(posedge clk);
        #1;
        arstN = 1'b0;
        for (int i = 0; i < memWords; i++)
        begin
            imem[i] = '0;
            dmem[i] = fillWord(addrWidth'(i));
        end
        progLen = 0;
        storeAddrLog.delete();
        storeDataLog.delete();
        expAddr.delete();
        expData.delete();
    endtask

    task automatic matchStores();
        int seen;
        int wanted;
        seen   = storeAddrLog.size();
        wanted = expAddr.size();
        for (int i = 0; i < seen && i < wanted; i++)
        begin
            compareValue("dataAddr", storeAddrLog[i], expAddr[i]);
            compareValue("dataOut", storeDataLog[i], expData[i]);
        end
        if (seen < wanted)
        begin
            errorCount++;
            $display("In %s only %0d of %0d expected stores appeared", testName, seen, wanted);
        end
        else if (seen > wanted)
        begin
            errorCount++;
            $display("In %s %0d stores appeared but only %0d were expected",
                     testName, seen, wanted);
        end
    endtask

    // Finishes the reset, runs the program and logs each store cycle
    task automatic runProgram();
        repeat (resetCycles)
        begin
            @(negedge clk);
            quietOutputs();
        end
        @(posedge clk);
        #1;
        arstN = 1'b1;
        @(negedge clk);
        quietOutputs();
        firstStoreCycle = 0;
        // Cycle 0 fetches word 0
        for (int cycle = 1; cycle <= testCycles; cycle++)
        begin
            @(negedge clk);
            if (dataWrite)
            begin
                if (storeAddrLog.size() == 0)
                    firstStoreCycle = cycle;
                storeAddrLog.push_back({2'b00, dataAddr});
                storeDataLog.push_back(dataOut);
                if (dataAddr[addrWidth-1:8] == '0)
                    dmem[dataAddr[7:0]] = dataOut;
            end
        end
        matchStores();
    endtask

    task automatic aluForwardTest();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sum;
        logic [31:0] diff;
        logic [31:0] andV;
        logic [31:0] orV;
        int          firstSw;
        a = nextRandom();
        b = nextRandom();
        sum  = a + b;
        diff = b - sum;
        andV = diff & sum;
        orV  = andV | a;
        startTest("alu forwarding");
        dmem[1] = a;
        dmem[2] = b;
        appendInstr(iFormat(opLw, 5'd1, 5'd0, 16'd4));
        appendInstr(iFormat(opLw, 5'd2, 5'd0, 16'd8));
        appendInstr('0);
        // Each result feeds the very next instruction
        appendInstr(rFormat(fnAdd, 5'd3, 5'd1, 5'd2));
        appendInstr(rFormat(fnSub, 5'd4, 5'd2, 5'd3));
        appendInstr(rFormat(fnAnd, 5'd5, 5'd4, 5'd3));
        appendInstr(rFormat(fnOr, 5'd6, 5'd5, 5'd1));
        appendInstr(rFormat(fnSlt, 5'd7, 5'd6, 5'd4));
        appendInstr(rFormat(fnSlt, 5'd8, 5'd4, 5'd6));
        firstSw = progLen;
        appendInstr(iFormat(opSw, 5'd8, 5'd0, 16'h0040));
        for (int r = 3; r <= 7; r++)
            appendInstr(iFormat(opSw, 5'(r), 5'd0, 16'(16'h0044 + 4 * (r - 3))));
        expectStore(32'd16, ($signed(diff) < $signed(orV)) ? 32'd1 : 32'd0);
        expectStore(32'd17, sum);
        expectStore(32'd18, diff);
        expectStore(32'd19, andV);
        expectStore(32'd20, orV);
        expectStore(32'd21, ($signed(orV) < $signed(diff)) ? 32'd1 : 32'd0);
        runProgram();
        // Without any stall a store reaches memory three cycles after its fetch
        compareValue("dataWrite cycle", firstStoreCycle, firstSw + 3);
    endtask

    task automatic immediateTest();
        logic [31:0] rnd;
        rnd = nextRandom();
        startTest("immediates");
        appendInstr(iFormat(opAddi, 5'd1, 5'd0, 16'hfffb));
        appendInstr(iFormat(opAddi, 5'd2, 5'd1, 16'hfed4));
        appendInstr(iFormat(opAddi, 5'd3, 5'd0, 16'h0100));
        appendInstr(iFormat(opAddi, 5'd4, 5'd0, rnd[15:0]));
        appendInstr(iFormat(opSw, 5'd1, 5'd3, 16'hfff8));
        appendInstr(iFormat(opSw, 5'd2, 5'd3, 16'h000c));
        appendInstr(iFormat(opSw, 5'd4, 5'd3, 16'h0000));
        expectStore((32'h100 + signExtend(16'hfff8)) >> 2, signExtend(16'hfffb));
        expectStore((32'h100 + signExtend(16'h000c)) >> 2,
                    signExtend(16'hfffb) + signExtend(16'hfed4));
        expectStore(32'h100 >> 2, signExtend(rnd[15:0]));
        runProgram();
    endtask

    task automatic loadUseTest();
        logic [31:0] value;
        logic [31:0] addend;
        value  = nextRandom();
        addend = nextRandom();
        startTest("load use");
        dmem[5] = value;
        appendInstr(iFormat(opAddi, 5'd2, 5'd0, addend[15:0]));
        appendInstr(iFormat(opAddi, 5'd1, 5'd0, 16'd20));
        appendInstr(iFormat(opLw, 5'd3, 5'd1, 16'd0));
        appendInstr(rFormat(fnAdd, 5'd4, 5'd3, 5'd2));
        appendInstr(iFormat(opSw, 5'd4, 5'd0, 16'h0080));
        // Store data straight from a load
        appendInstr(iFormat(opLw, 5'd5, 5'd1, 16'd4));
        appendInstr(iFormat(opSw, 5'd5, 5'd0, 16'h0084));
        expectStore(32'd32, value + signExtend(addend[15:0]));
        expectStore(32'd33, fillWord(30'd6));
        runProgram();
    endtask

    task automatic branchJumpTest();
        startTest("branch and jump");
        appendInstr(iFormat(opAddi, 5'd1, 5'd0, 16'd7));
        appendInstr(iFormat(opAddi, 5'd2, 5'd0, 16'd7));
        appendInstr(iFormat(opBeq, 5'd2, 5'd1, 16'd3));
        appendInstr(iFormat(opSw, 5'd1, 5'd0, 16'h0100));
        appendInstr(iFormat(opSw, 5'd0, 5'd0, 16'h0104));
        appendInstr(iFormat(opSw, 5'd0, 5'd0, 16'h0108));
        // Taken target at word 6
        appendInstr(iFormat(opAddi, 5'd3, 5'd0, 16'd9));
        // Stale r3 would equal r0 and take this branch
        appendInstr(iFormat(opBeq, 5'd0, 5'd3, 16'd4));
        appendInstr(iFormat(opSw, 5'd3, 5'd0, 16'h010c));
        appendInstr(iFormat(opSw, 5'd2, 5'd0, 16'h0110));
        appendInstr(jFormat(26'd13));
        appendInstr(iFormat(opSw, 5'd3, 5'd0, 16'h0114));
        appendInstr(iFormat(opSw, 5'd0, 5'd0, 16'h0118));
        appendInstr(iFormat(opSw, 5'd1, 5'd0, 16'h011c));
        expectStore(32'd64, 32'd7);
        expectStore(32'd67, 32'd9);
        expectStore(32'd68, 32'd7);
        expectStore(32'd69, 32'd9);
        expectStore(32'd71, 32'd7);
        runProgram();
    endtask

    initial
    begin
        arstN = 1'b0;
        for (int i = 0; i < memWords; i++)
        begin
            imem[i] = '0;
            dmem[i] = fillWord(addrWidth'(i));
        end
        aluForwardTest();
        immediateTest();
        loadUseTest();
        branchJumpTest();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* source/mipsCore.sv */
/*
 * Five-stage MIPS integer pipeline: fetch, decode, execute, memory
 * and writeback. BEQ and J resolve in decode with one delay slot.
 * Results forward into execute and into the decode comparator;
 * load-use and branch-operand hazards stall fetch and decode.
 * Both memories are word addressed and answer in the same cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
    input  logic                         clk,
    input  logic                         arstN,
    output logic [cpuPkg::addrWidth-1:0] instAddr,
    input  logic [cpuPkg::dataWidth-1:0] instData,
    output logic [cpuPkg::addrWidth-1:0] dataAddr,
    output logic                         dataWrite,
    output logic                         dataRead,
    output logic [cpuPkg::dataWidth-1:0] dataOut,
    input  logic [cpuPkg::dataWidth-1:0] dataIn
);
    import cpuPkg::*;

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] pcIn;
    logic                 stall;

    ifIdT  ifIdD;
    ifIdT  ifIdQ;
    idExT  idExD;
    idExT  idExQ;
    exMemT exMemD;
    exMemT exMemQ;
    memWbT memWbD;
    memWbT memWbQ;

    // Decode stage
    logic [opWidth-1:0]      opcode;
    logic [fnWidth-1:0]      funct;
    logic [regAddrWidth-1:0] idRs;
    logic [regAddrWidth-1:0] idRt;
    logic [regAddrWidth-1:0] idRd;
    logic [dataWidth-1:0]    signExtImm;
    logic [dataWidth-1:0]    branchTarget;
    logic [dataWidth-1:0]    jumpTarget;
    logic [dataWidth-1:0]    rsDataRf;
    logic [dataWidth-1:0]    rtDataRf;
    logic [dataWidth-1:0]    rsDataId;
    logic [dataWidth-1:0]    rtDataId;
    logic                    regsEqual;
    logic                    idIsBranch;
    pcSelT                   pcSel;
    logic                    regDest;
    logic                    aluSrcImm;
    aluOpT                   aluOp;
    logic                    memRead;
    logic                    memWrite;
    logic                    memToReg;
    logic                    regWrite;
    logic                    usesRs;
    logic                    usesRt;
    fwdSelT                  rsFwdId;
    fwdSelT                  rtFwdId;
    fwdSelT                  rsFwdEx;
    fwdSelT                  rtFwdEx;

    // Execute and writeback
    logic [dataWidth-1:0] aluA;
    logic [dataWidth-1:0] rtDataEx;
    logic [dataWidth-1:0] aluB;
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] wbData;

    function automatic logic [dataWidth-1:0] fwdMux(
        input fwdSelT               sel,
        input logic [dataWidth-1:0] regVal,
        input logic [dataWidth-1:0] memVal,
        input logic [dataWidth-1:0] wbVal
    );
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    // Fetch
    assign pcPlus4  = pc + dataWidth'(4);
    assign instAddr = pc[dataWidth-1:2];

    always_comb
    begin
        case (pcSel)
            pcBranch: pcIn = branchTarget;
            pcJump:   pcIn = jumpTarget;
            default:  pcIn = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            pc <= '0;
        else if (!stall)
            pc <= pcIn;
    end

    assign ifIdD.instr   = instData;
    assign ifIdD.pcPlus4 = pcPlus4;

    pipeReg #(.payloadT(ifIdT)) ifId (
        .clk   (clk),
        .arstN (arstN),
        .hold  (stall),
        .clear (1'b0),
        .d     (ifIdD),
        .q     (ifIdQ)
    );

    // Decode
    assign opcode = ifIdQ.instr[31:26];
    assign idRs   = ifIdQ.instr[25:21];
    assign idRt   = ifIdQ.instr[20:16];
    assign idRd   = ifIdQ.instr[15:11];
    assign funct  = ifIdQ.instr[fnWidth-1:0];

    assign signExtImm = {{(dataWidth - immWidth){ifIdQ.instr[immWidth-1]}},
                         ifIdQ.instr[immWidth-1:0]};
    assign branchTarget = ifIdQ.pcPlus4 + (signExtImm << 2);
    assign jumpTarget   = {ifIdQ.pcPlus4[31:28], ifIdQ.instr[jumpWidth-1:0], 2'b00};
    assign idIsBranch   = opcode == opBeq;

    regFile regs (
        .clk       (clk),
        .arstN     (arstN),
        .readAddrA (idRs),
        .readAddrB (idRt),
        .writeAddr (memWbQ.dest),
        .writeData (wbData),
        .writeEn   (memWbQ.regWrite),
        .readDataA (rsDataRf),
        .readDataB (rtDataRf)
    );

    assign rsDataId  = fwdMux(rsFwdId, rsDataRf, exMemQ.aluResult, wbData);
    assign rtDataId  = fwdMux(rtFwdId, rtDataRf, exMemQ.aluResult, wbData);
    assign regsEqual = rsDataId == rtDataId;

    controlUnit control (
        .opcode    (opcode),
        .funct     (funct),
        .regsEqual (regsEqual),
        .pcSel     (pcSel),
        .regDest   (regDest),
        .aluSrcImm (aluSrcImm),
        .aluOp     (aluOp),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .memToReg  (memToReg),
        .regWrite  (regWrite),
        .usesRs    (usesRs),
        .usesRt    (usesRt)
    );

    hazardUnit hazard (
        .idRs        (idRs),
        .idRt        (idRt),
        .idUsesRs    (usesRs),
        .idUsesRt    (usesRt),
        .idIsBranch  (idIsBranch),
        .exDest      (idExQ.dest),
        .exRegWrite  (idExQ.regWrite),
        .exMemRead   (idExQ.memRead),
        .memDest     (exMemQ.dest),
        .memRegWrite (exMemQ.regWrite),
        .memMemRead  (exMemQ.memRead),
        .exRs        (idExQ.rs),
        .exRt        (idExQ.rt),
        .wbDest      (memWbQ.dest),
        .wbRegWrite  (memWbQ.regWrite),
        .stall       (stall),
        .rsFwdId     (rsFwdId),
        .rtFwdId     (rtFwdId),
        .rsFwdEx     (rsFwdEx),
        .rtFwdEx     (rtFwdEx)
    );

    always_comb
    begin
        idExD.regWrite  = regWrite;
        idExD.memToReg  = memToReg;
        idExD.memRead   = memRead;
        idExD.memWrite  = memWrite;
        idExD.aluSrcImm = aluSrcImm;
        idExD.aluOp     = aluOp;
        idExD.rs        = idRs;
        idExD.rt        = idRt;
        idExD.dest      = regDest ? idRd : idRt;
        idExD.rsData    = rsDataId;
        idExD.rtData    = rtDataId;
        idExD.imm       = signExtImm;
    end

    // A stall leaves a bubble in execute
    pipeReg #(.payloadT(idExT)) idEx (
        .clk   (clk),
        .arstN (arstN),
        .hold  (1'b0),
        .clear (stall),
        .d     (idExD),
        .q     (idExQ)
    );

    // Execute
    assign aluA     = fwdMux(rsFwdEx, idExQ.rsData, exMemQ.aluResult, wbData);
    assign rtDataEx = fwdMux(rtFwdEx, idExQ.rtData, exMemQ.aluResult, wbData);
    assign aluB     = idExQ.aluSrcImm ? idExQ.imm : rtDataEx;

    aluUnit alu (
        .a      (aluA),
        .b      (aluB),
        .op     (idExQ.aluOp),
        .result (aluResult)
    );

    always_comb
    begin
        exMemD.regWrite  = idExQ.regWrite;
        exMemD.memToReg  = idExQ.memToReg;
        exMemD.memRead   = idExQ.memRead;
        exMemD.memWrite  = idExQ.memWrite;
        exMemD.aluResult = aluResult;
        exMemD.storeData = rtDataEx;
        exMemD.dest      = idExQ.dest;
    end

    pipeReg #(.payloadT(exMemT)) exMem (
        .clk   (clk),
        .arstN (arstN),
        .hold  (1'b0),
        .clear (1'b0),
        .d     (exMemD),
        .q     (exMemQ)
    );

    // Memory
    assign dataAddr  = exMemQ.aluResult[dataWidth-1:2];
    assign dataWrite = exMemQ.memWrite;
    assign dataRead  = exMemQ.memRead;
    assign dataOut   = exMemQ.storeData;

    always_comb
    begin
        memWbD.regWrite  = exMemQ.regWrite;
        memWbD.memToReg  = exMemQ.memToReg;
        memWbD.loadData  = dataIn;
        memWbD.aluResult = exMemQ.aluResult;
        memWbD.dest      = exMemQ.dest;
    end

    pipeReg #(.payloadT(memWbT)) memWb (
        .clk   (clk),
        .arstN (arstN),
        .hold  (1'b0),
        .clear (1'b0),
        .d     (memWbD),
        .q     (memWbQ)
    );

    // Writeback
    assign wbData = memWbQ.memToReg ? memWbQ.loadData : memWbQ.aluResult;

endmodule

`default_nettype wire

/* source/regFile.sv */
/*
 * General purpose register file, 32 x 32 bits.
 * Register zero is hardwired to zero; a write in the same cycle as
 * a read of that register is passed straight to the read port.
 */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic [cpuPkg::regAddrWidth-1:0] readAddrA,
    input  logic [cpuPkg::regAddrWidth-1:0] readAddrB,
    input  logic [cpuPkg::regAddrWidth-1:0] writeAddr,
    input  logic [cpuPkg::dataWidth-1:0]    writeData,
    input  logic                            writeEn,
    output logic [cpuPkg::dataWidth-1:0]    readDataA,
    output logic [cpuPkg::dataWidth-1:0]    readDataB
);
    import cpuPkg::*;

    logic [dataWidth-1:0] regs [1:(1 << regAddrWidth) - 1];

    function automatic logic [dataWidth-1:0] readPort(input logic [regAddrWidth-1:0] addr);
        if (addr == '0)
            return '0;
        if (writeEn && writeAddr == addr)
            return writeData;
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 1; i < (1 << regAddrWidth); i++)
                regs[i] <= '0;
        end
        else if (writeEn && writeAddr != '0)
            regs[writeAddr] <= writeData;
    end

    always_comb
    begin
        readDataA = readPort(readAddrA);
        readDataB = readPort(readAddrB);
    end

    assert property (@(posedge clk) disable iff (!arstN)
        (readAddrA != '0 || readDataA == '0) && (readAddrB != '0 || readDataB == '0))
        else $error("regFile: register zero read back nonzero");

endmodule

`default_nettype wire

/* source/pipeReg.sv */
/*
 * Pipeline stage register for any payload type.
 * hold keeps the current payload, clear loads the all-zero no-op.
 */
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    hold,
    input  logic    clear,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            q <= '0;
        else if (clear)
            q <= '0;
        else if (!hold)
            q <= d;
    end

    // Holding and flushing one stage at once would lose an instruction
    assert property (@(posedge clk) disable iff (!arstN) !(hold && clear))
        else $error("pipeReg: hold and clear both high");

endmodule

`default_nettype wire

/* source/hazardUnit.sv */
/*
 * Hazard and forwarding unit.
 * Raises the one-cycle stall for load-use and branch-operand cases
 * and picks the operand sources for the decode comparator and the ALU.
 */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  logic [cpuPkg::regAddrWidth-1:0] idRs,
    input  logic [cpuPkg::regAddrWidth-1:0] idRt,
    input  logic                            idUsesRs,
    input  logic                            idUsesRt,
    input  logic                            idIsBranch,
    input  logic [cpuPkg::regAddrWidth-1:0] exDest,
    input  logic                            exRegWrite,
    input  logic                            exMemRead,
    input  logic [cpuPkg::regAddrWidth-1:0] memDest,
    input  logic                            memRegWrite,
    input  logic                            memMemRead,
    input  logic [cpuPkg::regAddrWidth-1:0] exRs,
    input  logic [cpuPkg::regAddrWidth-1:0] exRt,
    input  logic [cpuPkg::regAddrWidth-1:0] wbDest,
    input  logic                            wbRegWrite,
    output logic                            stall,
    output cpuPkg::fwdSelT                  rsFwdId,
    output cpuPkg::fwdSelT                  rtFwdId,
    output cpuPkg::fwdSelT                  rsFwdEx,
    output cpuPkg::fwdSelT                  rtFwdEx
);
    import cpuPkg::*;

    logic exHitsId;
    logic memHitsId;
    logic loadUse;
    logic branchWait;

    // Memory stage wins over writeback, register zero never forwards
    function automatic fwdSelT pickSource(input logic [regAddrWidth-1:0] src);
        if (memRegWrite && memDest != '0 && memDest == src)
            return fwdMem;
        if (wbRegWrite && wbDest != '0 && wbDest == src)
            return fwdWb;
        return fwdReg;
    endfunction

    assign exHitsId = exDest != '0
        && ((idUsesRs && exDest == idRs) || (idUsesRt && exDest == idRt));
    assign memHitsId = memDest != '0
        && ((idUsesRs && memDest == idRs) || (idUsesRt && memDest == idRt));

    assign loadUse = exMemRead && exHitsId;
    // Load data never reaches the comparator, so a load in memory waits too
    assign branchWait = idIsBranch
        && ((exRegWrite && exHitsId) || (memMemRead && memHitsId));
    assign stall = loadUse || branchWait;

    always_comb
    begin
        rsFwdId = pickSource(idRs);
        rtFwdId = pickSource(idRt);
        rsFwdEx = pickSource(exRs);
        rtFwdEx = pickSource(exRt);
    end

    always_comb
    begin
        assert (memRegWrite || (rsFwdId != fwdMem && rtFwdId != fwdMem
                && rsFwdEx != fwdMem && rtFwdEx != fwdMem))
            else $error("hazardUnit: forward from memory stage that writes nothing");
        assert (wbRegWrite || (rsFwdId != fwdWb && rtFwdId != fwdWb
                && rsFwdEx != fwdWb && rtFwdEx != fwdWb))
            else $error("hazardUnit: forward from writeback stage that writes nothing");
    end

endmodule

`default_nettype wire

/* source/controlUnit.sv */
/*
 * Main decoder of the MIPS core.
 * Turns the decode-stage opcode and function field into control
 * levels, and picks the next PC for BEQ and J.
 */
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic [cpuPkg::opWidth-1:0] opcode,
    input  logic [cpuPkg::fnWidth-1:0] funct,
    input  logic                       regsEqual,
    output cpuPkg::pcSelT              pcSel,
    output logic                       regDest,
    output logic                       aluSrcImm,
    output cpuPkg::aluOpT              aluOp,
    output logic                       memRead,
    output logic                       memWrite,
    output logic                       memToReg,
    output logic                       regWrite,
    output logic                       usesRs,
    output logic                       usesRt
);
    import cpuPkg::*;

    logic rKnown;

    always_comb
    begin
        // Everything inactive unless the code is recognised
        pcSel     = pcNext;
        regDest   = 1'b0;
        aluSrcImm = 1'b0;
        aluOp     = aluAdd;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        regWrite  = 1'b0;
        usesRs    = 1'b0;
        usesRt    = 1'b0;
        rKnown    = 1'b0;
        case (opcode)
            opRType:
            begin
                rKnown = 1'b1;
                case (funct)
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    default: rKnown = 1'b0;
                endcase
                regDest  = rKnown;
                regWrite = rKnown;
                usesRs   = rKnown;
                usesRt   = rKnown;
            end
            opAddi:
            begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                usesRs    = 1'b1;
            end
            opLw:
            begin
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                memToReg  = 1'b1;
                regWrite  = 1'b1;
                usesRs    = 1'b1;
            end
            opSw:
            begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
                usesRs    = 1'b1;
                usesRt    = 1'b1;
            end
            opBeq:
            begin
                usesRs = 1'b1;
                usesRt = 1'b1;
                pcSel  = regsEqual ? pcBranch : pcNext;
            end
            opJ:     pcSel = pcJump;
            default: rKnown = 1'b0;
        endcase
    end

    // A load and a store can never share one memory cycle
    always_comb
    begin
        assert (!(memRead && memWrite))
            else $error("controlUnit: memRead and memWrite both high");
    end

endmodule

`default_nettype wire

/* source/aluUnit.sv */
/*
 * Integer ALU for the execute stage.
 * Add, subtract, AND, OR and signed set-less-than.
 */
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  logic [cpuPkg::dataWidth-1:0] a,
    input  logic [cpuPkg::dataWidth-1:0] b,
    input  cpuPkg::aluOpT                op,
    output logic [cpuPkg::dataWidth-1:0] result
);
    import cpuPkg::*;

    logic lessThan;

    // SLT compares as two's complement
    assign lessThan = $signed(a) < $signed(b);

    always_comb
    begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluSlt:  result = {{(dataWidth - 1){1'b0}}, lessThan};
            default: result = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* source/cpuPkg.sv */
/*
 * Shared definitions for the five-stage MIPS core.
 * Holds field widths, instruction codes, the control enumerations
 * and the payload that each pipeline register carries.
 */
`default_nettype none

package cpuPkg;

    // Datapath and instruction field widths
    localparam int dataWidth    = 32;
    localparam int addrWidth    = 30;
    localparam int regAddrWidth = 5;
    localparam int immWidth     = 16;
    localparam int jumpWidth    = 26;
    localparam int opWidth      = 6;
    localparam int fnWidth      = 6;

    // Primary opcodes
    localparam logic [opWidth-1:0] opRType = 6'h00;
    localparam logic [opWidth-1:0] opJ     = 6'h02;
    localparam logic [opWidth-1:0] opBeq   = 6'h04;
    localparam logic [opWidth-1:0] opAddi  = 6'h08;
    localparam logic [opWidth-1:0] opLw    = 6'h23;
    localparam logic [opWidth-1:0] opSw    = 6'h2b;

    // R-type function codes
    localparam logic [fnWidth-1:0] fnAdd = 6'h20;
    localparam logic [fnWidth-1:0] fnSub = 6'h22;
    localparam logic [fnWidth-1:0] fnAnd = 6'h24;
    localparam logic [fnWidth-1:0] fnOr  = 6'h25;
    localparam logic [fnWidth-1:0] fnSlt = 6'h2a;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOpT;
    typedef enum logic [1:0] {pcNext, pcBranch, pcJump} pcSelT;
    typedef enum logic [1:0] {fwdReg, fwdMem, fwdWb} fwdSelT;

    typedef struct packed {
        logic [dataWidth-1:0] instr;
        logic [dataWidth-1:0] pcPlus4;
    } ifIdT;

    // An all-zero payload is a no-op in every stage
    typedef struct packed {
        logic                    regWrite;
        logic                    memToReg;
        logic                    memRead;
        logic                    memWrite;
        logic                    aluSrcImm;
        aluOpT                   aluOp;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] dest;
        logic [dataWidth-1:0]    rsData;
        logic [dataWidth-1:0]    rtData;
        logic [dataWidth-1:0]    imm;
    } idExT;

    typedef struct packed {
        logic                    regWrite;
        logic                    memToReg;
        logic                    memRead;
        logic                    memWrite;
        logic [dataWidth-1:0]    aluResult;
        logic [dataWidth-1:0]    storeData;
        logic [regAddrWidth-1:0] dest;
    } exMemT;

    typedef struct packed {
        logic                    regWrite;
        logic                    memToReg;
        logic [dataWidth-1:0]    loadData;
        logic [dataWidth-1:0]    aluResult;
        logic [regAddrWidth-1:0] dest;
    } memWbT;

endpackage

`default_nettype wire
